//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;
	// One strobe bit per byte lane
	typedef logic [xlen/8-1:0] strb_t;

	// One-hot controller states
	typedef enum logic [7:0] {
		st_fetch      = 8'b0000_0001,
		st_fetch_wait = 8'b0000_0010,
		st_decode     = 8'b0000_0100,
		st_execute    = 8'b0000_1000,
		st_load       = 8'b0001_0000,
		st_store      = 8'b0010_0000,
		st_load_wait  = 8'b0100_0000,
		st_writeback  = 8'b1000_0000
	} state_t;

endpackage

`default_nettype wire

//--- hw/rv_core_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_ctrl #(
	parameter core_pkg::word_t reset_pc = '0
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 inst_req_ready,
	input  logic                 inst_valid,
	input  logic                 mem_req_ready,
	input  logic                 mem_rdata_valid,
	input  core_pkg::reg_addr_t  rd,
	input  logic [2:0]           funct3,
	input  core_pkg::word_t      imm,
	input  logic                 op_a_pc,
	input  logic                 op_b_imm,
	input  logic                 is_load,
	input  logic                 is_store,
	input  logic                 is_branch,
	input  logic                 is_jal,
	input  logic                 is_jalr,
	input  logic                 is_lui,
	input  logic                 writes_rd,
	input  core_pkg::word_t      rdata1,
	input  core_pkg::word_t      rdata2,
	input  core_pkg::word_t      alu_result,
	input  core_pkg::word_t      load_value,
	output core_pkg::word_t      inst_addr,
	output logic                 inst_req_valid,
	output logic                 inst_ready,
	output logic                 inst_capture,
	output core_pkg::word_t      mem_addr,
	output logic                 mem_read,
	output logic                 mem_write,
	output logic                 mem_rdata_ready,
	output logic                 rdata_capture,
	output core_pkg::word_t      store_data,
	output logic [1:0]           byte_offset,
	output core_pkg::word_t      op_a,
	output core_pkg::word_t      op_b,
	output logic                 rf_wen,
	output core_pkg::reg_addr_t  rf_waddr,
	output core_pkg::word_t      rf_wdata,
	output logic                 retire_valid,
	output core_pkg::word_t      retire_pc,
	output logic                 retire_wen,
	output core_pkg::reg_addr_t  retire_rd,
	output core_pkg::word_t      retire_wdata
);

	core_pkg::state_t state;
	core_pkg::state_t next_state;
	core_pkg::word_t  pc;
	core_pkg::word_t  npc;
	core_pkg::word_t  next_pc;
	core_pkg::word_t  pc_plus4;
	core_pkg::word_t  pc_imm;
	core_pkg::word_t  result;
	logic             taken;
	// Branches and unknown opcodes end in execute
	logic             exec_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= core_pkg::st_fetch;
		end else begin
			state <= next_state;
		end
	end

	assign exec_done = ~(is_load | is_store | writes_rd);

	always_comb begin
		next_state = state;
		case (state)
			core_pkg::st_fetch:
				if (inst_req_ready) next_state = core_pkg::st_fetch_wait;
			core_pkg::st_fetch_wait:
				if (inst_valid) next_state = core_pkg::st_decode;
			core_pkg::st_decode:
				next_state = core_pkg::st_execute;
			core_pkg::st_execute: begin
				if (is_load) begin
					next_state = core_pkg::st_load;
				end else if (is_store) begin
					next_state = core_pkg::st_store;
				end else if (writes_rd) begin
					next_state = core_pkg::st_writeback;
				end else begin
					next_state = core_pkg::st_fetch;
				end
			end
			core_pkg::st_load:
				if (mem_req_ready) next_state = core_pkg::st_load_wait;
			// Store retires on acceptance
			core_pkg::st_store:
				if (mem_req_ready) next_state = core_pkg::st_fetch;
			core_pkg::st_load_wait:
				if (mem_rdata_valid) next_state = core_pkg::st_writeback;
			default:
				next_state = core_pkg::st_fetch;
		endcase
	end

	// Bus handshakes straight from the state
	assign inst_addr       = pc;
	assign inst_req_valid  = state == core_pkg::st_fetch;
	assign inst_ready      = state == core_pkg::st_fetch_wait;
	assign inst_capture    = inst_ready & inst_valid;
	assign mem_read        = state == core_pkg::st_load;
	assign mem_write       = state == core_pkg::st_store;
	assign mem_rdata_ready = state == core_pkg::st_load_wait;
	assign rdata_capture   = mem_rdata_ready & mem_rdata_valid;

	// Result holds the effective address through the memory states
	assign mem_addr    = {result[core_pkg::xlen-1:2], 2'b00};
	assign byte_offset = result[1:0];

	// Operands in decode, result and next PC in execute
	always_ff @(posedge clk) begin
		if (state == core_pkg::st_decode) begin
			op_a       <= op_a_pc ? pc : rdata1;
			op_b       <= op_b_imm ? imm : rdata2;
			store_data <= rdata2;
		end
		if (state == core_pkg::st_execute) begin
			result <= alu_result;
			npc    <= next_pc;
		end
	end

	// Branch decision
	// Zero result for equality, bit 0 of SLT/SLTU otherwise
	always_comb begin
		case (funct3)
			rv_isa_pkg::f3_beq:  taken = alu_result == '0;
			rv_isa_pkg::f3_bne:  taken = alu_result != '0;
			rv_isa_pkg::f3_blt,
			rv_isa_pkg::f3_bltu: taken = alu_result[0];
			rv_isa_pkg::f3_bge,
			rv_isa_pkg::f3_bgeu: taken = ~alu_result[0];
			default:             taken = 1'b0;
		endcase
	end

	// Own adders for sequential and relative targets
	assign pc_plus4 = pc + core_pkg::word_t'(4);
	assign pc_imm   = pc + imm;

	always_comb begin
		if (is_jal || (is_branch && taken)) begin
			next_pc = pc_imm;
		end else if (is_jalr) begin
			// JALR target with bit 0 cleared
			next_pc = {alu_result[core_pkg::xlen-1:1], 1'b0};
		end else begin
			next_pc = pc_plus4;
		end
	end

	// Write-back source
	always_comb begin
		if (is_load) begin
			rf_wdata = load_value;
		end else if (is_jal || is_jalr) begin
			// Link address
			rf_wdata = pc_plus4;
		end else if (is_lui) begin
			rf_wdata = imm;
		end else begin
			rf_wdata = result;
		end
	end

	assign rf_wen   = (state == core_pkg::st_writeback) & writes_rd;
	assign rf_waddr = rd;

	// One retire pulse per instruction
	assign retire_valid = (state == core_pkg::st_writeback) |
		((state == core_pkg::st_store) & mem_req_ready) |
		((state == core_pkg::st_execute) & exec_done);
	assign retire_pc    = pc;
	assign retire_wen   = rf_wen;
	assign retire_rd    = rd;
	assign retire_wdata = rf_wdata;

	// PC moves on at retire
	// Execute-cycle retires take the target directly
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (retire_valid) begin
			pc <= (state == core_pkg::st_execute) ? next_pc : npc;
		end
	end

endmodule

`default_nettype wire

//--- hw/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input  logic                 clk,
	input  core_pkg::word_t      inst_data,
	input  logic                 inst_capture,
	output core_pkg::reg_addr_t  rs1,
	output core_pkg::reg_addr_t  rs2,
	output core_pkg::reg_addr_t  rd,
	output logic [2:0]           funct3,
	output core_pkg::word_t      imm,
	output rv_isa_pkg::alu_op_t  alu_op,
	output logic                 op_a_pc,
	output logic                 op_b_imm,
	output logic                 is_load,
	output logic                 is_store,
	output logic                 is_branch,
	output logic                 is_jal,
	output logic                 is_jalr,
	output logic                 is_lui,
	output logic                 writes_rd
);

	core_pkg::word_t inst;
	logic [6:0]      opcode;
	logic            is_op;
	logic            is_op_imm;
	logic            is_auipc;
	// funct7 bit 5, selects SUB and SRA
	logic            alt_op;

	// Instruction register, loaded on the fetch response
	always_ff @(posedge clk) begin
		if (inst_capture) begin
			inst <= inst_data;
		end
	end

	assign opcode = inst[6:0];
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign alt_op = inst[30];

	// Instruction class
	assign is_op     = opcode == rv_isa_pkg::opc_op;
	assign is_op_imm = opcode == rv_isa_pkg::opc_op_imm;
	assign is_load   = opcode == rv_isa_pkg::opc_load;
	assign is_store  = opcode == rv_isa_pkg::opc_store;
	assign is_branch = opcode == rv_isa_pkg::opc_branch;
	assign is_jal    = opcode == rv_isa_pkg::opc_jal;
	assign is_jalr   = opcode == rv_isa_pkg::opc_jalr;
	assign is_lui    = opcode == rv_isa_pkg::opc_lui;
	assign is_auipc  = opcode == rv_isa_pkg::opc_auipc;

	// Unknown opcodes write nothing
	assign writes_rd = is_op | is_op_imm | is_load | is_jal | is_jalr | is_lui | is_auipc;

	// PC only feeds the ALU for AUIPC
	assign op_a_pc  = is_auipc;
	// Register compare for R-type and branches, immediate otherwise
	assign op_b_imm = ~(is_op | is_branch);

	// Immediate format by opcode
	always_comb begin
		case (opcode)
			rv_isa_pkg::opc_store:
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			rv_isa_pkg::opc_branch:
				imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			rv_isa_pkg::opc_lui, rv_isa_pkg::opc_auipc:
				imm = {inst[31:12], 12'b0};
			rv_isa_pkg::opc_jal:
				imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			// I format, sign-extended even for SLTIU
			default:
				imm = {{20{inst[31]}}, inst[31:20]};
		endcase
	end

	// ALU operation
	always_comb begin
		alu_op = rv_isa_pkg::alu_add;
		if (is_op || is_op_imm) begin
			case (funct3)
				3'b000: alu_op = (is_op && alt_op) ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
				3'b001: alu_op = rv_isa_pkg::alu_sll;
				3'b010: alu_op = rv_isa_pkg::alu_slt;
				3'b011: alu_op = rv_isa_pkg::alu_sltu;
				3'b100: alu_op = rv_isa_pkg::alu_xor;
				// SRAI carries the same bit 30 as SRA
				3'b101: alu_op = alt_op ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
				3'b110: alu_op = rv_isa_pkg::alu_or;
				default: alu_op = rv_isa_pkg::alu_and;
			endcase
		end else if (is_branch) begin
			case (funct3)
				// Equality from a zero difference
				rv_isa_pkg::f3_beq, rv_isa_pkg::f3_bne: alu_op = rv_isa_pkg::alu_sub;
				rv_isa_pkg::f3_blt, rv_isa_pkg::f3_bge: alu_op = rv_isa_pkg::alu_slt;
				default: alu_op = rv_isa_pkg::alu_sltu;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/rv_exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_unit (
	input  core_pkg::word_t      op_a,
	input  core_pkg::word_t      op_b,
	input  rv_isa_pkg::alu_op_t  alu_op,
	output core_pkg::word_t      result
);

	logic [4:0]              shamt;
	core_pkg::word_t         sum;
	core_pkg::word_t         diff;
	logic                    lt_signed;
	logic                    lt_unsigned;
	logic                    shift_fill;
	logic [core_pkg::xlen:0] shift_right;

	// Shift amount from the low bits only
	assign shamt = op_b[4:0];

	assign sum  = op_a + op_b;
	assign diff = op_a - op_b;

	// Signs differ: a is less when negative
	// Signs equal: difference cannot overflow
	assign lt_signed   = (op_a[core_pkg::xlen-1] != op_b[core_pkg::xlen-1]) ?
		op_a[core_pkg::xlen-1] : diff[core_pkg::xlen-1];
	assign lt_unsigned = op_a < op_b;

	// One right shifter for SRL and SRA
	// Extra top bit is the fill value
	assign shift_fill  = (alu_op == rv_isa_pkg::alu_sra) & op_a[core_pkg::xlen-1];
	assign shift_right = $signed({shift_fill, op_a}) >>> shamt;

	always_comb begin
		case (alu_op)
			rv_isa_pkg::alu_add:  result = sum;
			rv_isa_pkg::alu_sub:  result = diff;
			rv_isa_pkg::alu_sll:  result = op_a << shamt;
			rv_isa_pkg::alu_slt:  result = core_pkg::word_t'(lt_signed);
			rv_isa_pkg::alu_sltu: result = core_pkg::word_t'(lt_unsigned);
			rv_isa_pkg::alu_xor:  result = op_a ^ op_b;
			rv_isa_pkg::alu_srl,
			rv_isa_pkg::alu_sra:  result = shift_right[core_pkg::xlen-1:0];
			rv_isa_pkg::alu_or:   result = op_a | op_b;
			rv_isa_pkg::alu_and:  result = op_a & op_b;
			default:              result = sum;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// Major opcodes, instruction bits 6:0
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;

	// Access width for loads and stores
	localparam logic [2:0] f3_byte   = 3'b000;
	localparam logic [2:0] f3_half   = 3'b001;
	localparam logic [2:0] f3_word   = 3'b010;
	// Zero-extending loads
	localparam logic [2:0] f3_byte_u = 3'b100;
	localparam logic [2:0] f3_half_u = 3'b101;

	// Branch conditions
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// Operations of the execute unit
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_t;

endpackage

`default_nettype wire

//--- hw/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
	input  logic             clk,
	input  logic [2:0]       funct3,
	input  logic [1:0]       byte_offset,
	input  core_pkg::word_t  store_data,
	input  core_pkg::word_t  rdata,
	input  logic             rdata_capture,
	output core_pkg::word_t  wdata,
	output core_pkg::strb_t  wstrb,
	output core_pkg::word_t  load_value
);

	core_pkg::word_t rdata_q;
	logic [7:0]      load_byte;
	logic [15:0]     load_half;

	// Store lanes, data copied to every lane
	// Strobe picks the addressed ones
	always_comb begin
		case (funct3)
			rv_isa_pkg::f3_byte: begin
				wdata = {4{store_data[7:0]}};
				wstrb = 4'b0001 << byte_offset;
			end
			rv_isa_pkg::f3_half: begin
				wdata = {2{store_data[15:0]}};
				wstrb = byte_offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				wdata = store_data;
				wstrb = 4'b1111;
			end
		endcase
	end

	// Read data held from the response until write-back
	always_ff @(posedge clk) begin
		if (rdata_capture) begin
			rdata_q <= rdata;
		end
	end

	assign load_byte = rdata_q[{byte_offset, 3'b000} +: 8];
	assign load_half = byte_offset[1] ? rdata_q[31:16] : rdata_q[15:0];

	// Extension by funct3
	always_comb begin
		case (funct3)
			rv_isa_pkg::f3_byte:   load_value = {{24{load_byte[7]}}, load_byte};
			rv_isa_pkg::f3_byte_u: load_value = {24'b0, load_byte};
			rv_isa_pkg::f3_half:   load_value = {{16{load_half[15]}}, load_half};
			rv_isa_pkg::f3_half_u: load_value = {16'b0, load_half};
			default:               load_value = rdata_q;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/rv_multicycle_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_multicycle_core #(
	parameter core_pkg::word_t reset_pc = '0
) (
	input  logic                 clk,
	input  logic                 rst,
	output core_pkg::word_t      inst_addr,
	output logic                 inst_req_valid,
	input  logic                 inst_req_ready,
	input  core_pkg::word_t      inst_data,
	input  logic                 inst_valid,
	output logic                 inst_ready,
	output core_pkg::word_t      mem_addr,
	output logic                 mem_read,
	output logic                 mem_write,
	output core_pkg::word_t      mem_wdata,
	output core_pkg::strb_t      mem_wstrb,
	input  logic                 mem_req_ready,
	input  core_pkg::word_t      mem_rdata,
	input  logic                 mem_rdata_valid,
	output logic                 mem_rdata_ready,
	output logic                 retire_valid,
	output core_pkg::word_t      retire_pc,
	output logic                 retire_wen,
	output core_pkg::reg_addr_t  retire_rd,
	output core_pkg::word_t      retire_wdata
);

	// Decoded instruction
	core_pkg::reg_addr_t rs1;
	core_pkg::reg_addr_t rs2;
	core_pkg::reg_addr_t rd;
	logic [2:0]          funct3;
	core_pkg::word_t     imm;
	rv_isa_pkg::alu_op_t alu_op;
	logic                op_a_pc;
	logic                op_b_imm;
	logic                is_load;
	logic                is_store;
	logic                is_branch;
	logic                is_jal;
	logic                is_jalr;
	logic                is_lui;
	logic                writes_rd;

	// Datapath between controller and units
	logic                inst_capture;
	logic                rdata_capture;
	core_pkg::word_t     store_data;
	logic [1:0]          byte_offset;
	core_pkg::word_t     op_a;
	core_pkg::word_t     op_b;
	core_pkg::word_t     rdata1;
	core_pkg::word_t     rdata2;
	core_pkg::word_t     alu_result;
	core_pkg::word_t     load_value;
	logic                rf_wen;
	core_pkg::reg_addr_t rf_waddr;
	core_pkg::word_t     rf_wdata;

	// Port names match the signals above
	rv_core_ctrl #(
		.reset_pc(reset_pc)
	) u_ctrl (.*);

	rv_decoder u_decoder (.*);

	rv_exec_unit u_exec (
		.op_a   (op_a),
		.op_b   (op_b),
		.alu_op (alu_op),
		.result (alu_result)
	);

	rv_regfile u_regfile (
		.clk    (clk),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.waddr  (rf_waddr),
		.wdata  (rf_wdata),
		.wen    (rf_wen),
		.rdata1 (rdata1),
		.rdata2 (rdata2)
	);

	rv_lsu u_lsu (
		.clk           (clk),
		.funct3        (funct3),
		.byte_offset   (byte_offset),
		.store_data    (store_data),
		.rdata         (mem_rdata),
		.rdata_capture (rdata_capture),
		.wdata         (mem_wdata),
		.wstrb         (mem_wstrb),
		.load_value    (load_value)
	);

endmodule

`default_nettype wire

//--- hw/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  logic                 clk,
	input  core_pkg::reg_addr_t  raddr1,
	input  core_pkg::reg_addr_t  raddr2,
	input  core_pkg::reg_addr_t  waddr,
	input  core_pkg::word_t      wdata,
	input  logic                 wen,
	output core_pkg::word_t      rdata1,
	output core_pkg::word_t      rdata2
);

	core_pkg::word_t regs [0:31];

	// x0 never written
	always_ff @(posedge clk) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Asynchronous reads, x0 forced to zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- project.f
+incdir+tests
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/rv_decoder.sv
hw/rv_exec_unit.sv
hw/rv_regfile.sv
hw/rv_lsu.sv
hw/rv_core_ctrl.sv
hw/rv_multicycle_core.sv
tests/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_core -f project.f -o tb_core

out="$(./obj_dir/tb_core)"
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
	exit 0
else
	exit 1
fi

//--- tests/tb_iss.svh
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

logic [31:0] imem [0:63];
logic [31:0] ref_mem [0:1023];
logic [31:0] ref_regs [0:31];
logic [31:0] ref_pc;
int          prog_len;
logic [31:0] rng_state = 32'd79316;

// Expected retire of the latest reference step
logic [31:0] exp_pc;
logic        exp_wen;
logic [4:0]  exp_rd;
logic [31:0] exp_wdata;
logic        exp_store;
logic [31:0] exp_saddr;
logic [31:0] exp_swdata;
logic [3:0]  exp_sstrb;

function automatic logic [31:0] next_random();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

// Stall about one cycle in four, never more than 3 in a row
function automatic logic stall_pick(input int stalls);
	logic [31:0] r;
	r = next_random();
	return (stalls < 3) && (r[1:0] == 2'b00);
endfunction

function automatic int response_delay();
	logic [31:0] r;
	r = next_random();
	return int'(r[1:0]);
endfunction

// Data memory contents before any store
function automatic logic [31:0] fill_word(input int i);
	return {i[15:0] ^ 16'ha5c3, ~i[15:0]};
endfunction

// Encoders for the RV32I formats
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
	return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
	input logic [6:0] opc);
	return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

function automatic void emit(input logic [31:0] w);
	imem[prog_len] = w;
	prog_len = prog_len + 1;
endfunction

function automatic void build_program();
	for (int i = 0; i < 64; i++) begin
		imem[i] = 32'h0;
	end
	prog_len = 0;
	// Arithmetic, compares and shifts
	emit(enc_i(12'hffb, 5'd0, 3'd0, 5'd1, 7'h13));
	emit(enc_i(12'h007, 5'd0, 3'd0, 5'd2, 7'h13));
	emit(enc_u(20'h80000, 5'd3, 7'h37));
	emit(enc_u(20'h12345, 5'd4, 7'h17));
	emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd5));
	emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd6));
	emit(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd7));
	emit(enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd8));
	emit(enc_r(7'h20, 5'd2, 5'd3, 3'd5, 5'd9));
	emit(enc_r(7'h00, 5'd2, 5'd3, 3'd5, 5'd10));
	emit(enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd11));
	emit(enc_i(12'h0f0, 5'd1, 3'd4, 5'd12, 7'h13));
	emit(enc_i(12'h03c, 5'd1, 3'd7, 5'd13, 7'h13));
	emit(enc_i(12'hfff, 5'd2, 3'd3, 5'd14, 7'h13));
	emit(enc_i(12'h404, 5'd3, 3'd5, 5'd24, 7'h13));
	emit(enc_i(12'h055, 5'd1, 3'd6, 5'd25, 7'h13));
	// Write to x0, then read it back
	emit(enc_i(12'h005, 5'd2, 3'd0, 5'd0, 7'h13));
	emit(enc_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd15));
	// Stores around base 0x100
	emit(enc_i(12'h100, 5'd0, 3'd0, 5'd16, 7'h13));
	emit(enc_u(20'h89abd, 5'd17, 7'h37));
	emit(enc_i(12'hdef, 5'd17, 3'd0, 5'd17, 7'h13));
	emit(enc_s(12'd0, 5'd17, 5'd16, 3'd2));
	emit(enc_s(12'd5, 5'd1, 5'd16, 3'd0));
	emit(enc_s(12'd10, 5'd1, 5'd16, 3'd1));
	emit(enc_s(12'd7, 5'd2, 5'd16, 3'd0));
	emit(enc_s(12'd12, 5'd17, 5'd16, 3'd1));
	// Loads at every byte offset
	emit(enc_i(12'd1, 5'd16, 3'd0, 5'd18, 7'h03));
	emit(enc_i(12'd3, 5'd16, 3'd4, 5'd19, 7'h03));
	emit(enc_i(12'd2, 5'd16, 3'd1, 5'd20, 7'h03));
	emit(enc_i(12'd0, 5'd16, 3'd5, 5'd26, 7'h03));
	emit(enc_i(12'd4, 5'd16, 3'd2, 5'd27, 7'h03));
	emit(enc_i(12'd5, 5'd16, 3'd0, 5'd28, 7'h03));
	emit(enc_i(12'd6, 5'd16, 3'd4, 5'd29, 7'h03));
	emit(enc_i(12'd10, 5'd16, 3'd1, 5'd30, 7'h03));
	emit(enc_i(12'd14, 5'd16, 3'd5, 5'd31, 7'h03));
	emit(enc_i(12'h203, 5'd0, 3'd0, 5'd18, 7'h03));
	// Branches, taken ones skip a marker
	emit(enc_b(13'd8, 5'd2, 5'd2, 3'd0));
	emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd5, 7'h13));
	emit(enc_b(13'd8, 5'd1, 5'd1, 3'd1));
	emit(enc_b(13'd8, 5'd2, 5'd1, 3'd4));
	emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd5, 7'h13));
	emit(enc_b(13'd8, 5'd2, 5'd1, 3'd5));
	emit(enc_b(13'd8, 5'd2, 5'd1, 3'd6));
	emit(enc_b(13'd8, 5'd2, 5'd1, 3'd7));
	emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd5, 7'h13));
	emit(enc_b(13'd8, 5'd1, 5'd2, 3'd5));
	emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd5, 7'h13));
	// Opposite outcome of each condition
	emit(enc_b(13'd8, 5'd2, 5'd1, 3'd0));
	emit(enc_b(13'd8, 5'd2, 5'd1, 3'd1));
	emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd5, 7'h13));
	emit(enc_b(13'd8, 5'd1, 5'd2, 3'd4));
	emit(enc_b(13'd8, 5'd1, 5'd2, 3'd6));
	emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd5, 7'h13));
	emit(enc_b(13'd8, 5'd1, 5'd2, 3'd7));
	// Jumps, JALR with an odd target sum
	emit(enc_j(21'd8, 5'd21));
	emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd5, 7'h13));
	emit(enc_i(12'(prog_len * 4 + 9), 5'd0, 3'd0, 5'd22, 7'h67));
	emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd5, 7'h13));
	// Unknown opcodes
	emit(32'h0000007f);
	emit(32'h00000000);
	emit(enc_j(21'd0, 5'd0));
endfunction

`endif

//--- tests/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;

	localparam int n_steps = 64;
	localparam logic [31:0] reset_pc = 32'h0;

	logic        clk;
	logic        rst;
	logic [31:0] inst_addr;
	logic        inst_req_valid;
	logic        inst_req_ready;
	logic [31:0] inst_data;
	logic        inst_valid;
	logic        inst_ready;
	logic [31:0] mem_addr;
	logic        mem_read;
	logic        mem_write;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	logic        mem_req_ready;
	logic [31:0] mem_rdata;
	logic        mem_rdata_valid;
	logic        mem_rdata_ready;
	logic        retire_valid;
	logic [31:0] retire_pc;
	logic        retire_wen;
	logic [4:0]  retire_rd;
	logic [31:0] retire_wdata;

	`include "tb_iss.svh"

	logic [31:0] dmem [0:1023];
	int          errors;
	int          n_retired;
	logic        seen_req;
	// Bus model state
	logic        ipend;
	logic        dpend;
	int          idelay;
	int          ddelay;
	int          istall;
	int          dstall;
	logic        ireq_wait;
	logic        mreq_wait;
	logic [31:0] ireq_addr;
	logic [31:0] mreq_addr;
	logic [31:0] mreq_wdata;
	logic [3:0]  mreq_strb;
	logic        mreq_write;

	rv_multicycle_core #(
		.reset_pc(reset_pc)
	) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		inst_req_ready = 1'b0;
		inst_data = '0;
		inst_valid = 1'b0;
		mem_req_ready = 1'b0;
		mem_rdata = '0;
		mem_rdata_valid = 1'b0;
		errors = 0;
		n_retired = 0;
		seen_req = 1'b0;
		build_program();
		for (int i = 0; i < 1024; i++) begin
			dmem[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		for (int i = 0; i < 32; i++) begin
			ref_regs[i] = '0;
		end
		ref_pc = reset_pc;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		#1;
		if (retire_valid || mem_read || mem_write) begin
			errors++;
			$display("Retire or data request active right after reset");
		end
		wait (n_retired == n_steps);
		@(negedge clk);
		$display("%0d errors over %0d retired instructions", errors, n_retired);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (400 * n_steps) @(posedge clk);
		$display("Timeout with %0d of %0d instructions retired", n_retired, n_steps);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// Compare process
	always @(posedge clk) begin
		if (!rst && n_retired < n_steps) begin
			if (inst_req_valid && !seen_req) begin
				seen_req = 1'b1;
				if (inst_addr !== reset_pc) begin
					errors++;
					$display("Fail inst_addr expected %h actual %h", reset_pc, inst_addr);
				end
			end
			if (retire_valid) begin
				ref_step();
				n_retired++;
				if (retire_pc !== exp_pc) begin
					errors++;
					$display("Fail retire_pc expected %h actual %h", exp_pc, retire_pc);
				end
				if (retire_wen !== exp_wen) begin
					errors++;
					$display("Fail retire_wen expected %h actual %h", exp_wen, retire_wen);
				end
				if (exp_wen && retire_rd !== exp_rd) begin
					errors++;
					$display("Fail retire_rd expected %h actual %h", exp_rd, retire_rd);
				end
				if (exp_wen && retire_wdata !== exp_wdata) begin
					errors++;
					$display("Fail retire_wdata expected %h actual %h", exp_wdata, retire_wdata);
				end
				if (exp_store && !(mem_write && mem_req_ready)) begin
					errors++;
					$display("Store retired without an accepted write at pc %h", exp_pc);
				end
				if (exp_store && mem_addr !== exp_saddr) begin
					errors++;
					$display("Fail mem_addr expected %h actual %h", exp_saddr, mem_addr);
				end
				if (exp_store && mem_wdata !== exp_swdata) begin
					errors++;
					$display("Fail mem_wdata expected %h actual %h", exp_swdata, mem_wdata);
				end
				if (exp_store && mem_wstrb !== exp_sstrb) begin
					errors++;
					$display("Fail mem_wstrb expected %h actual %h", exp_sstrb, mem_wstrb);
				end
			end
		end
	end

	// Instruction and data memories with random stalls
	always @(posedge clk) begin : bus_model
		logic s;
		if (rst) begin
			inst_req_ready <= 1'b0;
			inst_valid <= 1'b0;
			mem_req_ready <= 1'b0;
			mem_rdata_valid <= 1'b0;
			ipend = 1'b0;
			dpend = 1'b0;
			istall = 0;
			dstall = 0;
			ireq_wait = 1'b0;
			mreq_wait = 1'b0;
		end else begin
			s = stall_pick(istall);
			inst_req_ready <= !s;
			istall = s ? istall + 1 : 0;
			s = stall_pick(dstall);
			mem_req_ready <= !s;
			dstall = s ? dstall + 1 : 0;

			// Waiting requests hold still
			if (ireq_wait && (!inst_req_valid || inst_addr !== ireq_addr)) begin
				errors++;
				$display("Instruction request dropped or changed before acceptance");
			end
			if (mreq_wait && (mem_write !== mreq_write || !(mem_read || mem_write) ||
				mem_addr !== mreq_addr ||
				(mreq_write && (mem_wdata !== mreq_wdata || mem_wstrb !== mreq_strb)))) begin
				errors++;
				$display("Data request dropped or changed before acceptance");
			end
			ireq_wait = inst_req_valid && !inst_req_ready;
			ireq_addr = inst_addr;
			mreq_wait = (mem_read || mem_write) && !mem_req_ready;
			mreq_addr = mem_addr;
			mreq_wdata = mem_wdata;
			mreq_strb = mem_wstrb;
			mreq_write = mem_write;

			// Instruction response
			if (inst_valid && inst_ready) begin
				inst_valid <= 1'b0;
				ipend = 1'b0;
			end else if (ipend && !inst_valid) begin
				if (idelay <= 1) inst_valid <= 1'b1;
				idelay = idelay - 1;
			end
			if (inst_req_valid && inst_req_ready) begin
				ipend = 1'b1;
				idelay = response_delay();
				inst_data <= imem[inst_addr[7:2]];
				inst_valid <= (idelay == 0);
			end

			// Data response
			if (mem_rdata_valid && mem_rdata_ready) begin
				mem_rdata_valid <= 1'b0;
				dpend = 1'b0;
			end else if (dpend && !mem_rdata_valid) begin
				if (ddelay <= 1) mem_rdata_valid <= 1'b1;
				ddelay = ddelay - 1;
			end
			if ((mem_read || mem_write) && mem_req_ready) begin
				if (mem_write) begin
					for (int b = 0; b < 4; b++) begin
						if (mem_wstrb[b]) dmem[mem_addr[11:2]][8*b +: 8] = mem_wdata[8*b +: 8];
					end
				end else begin
					dpend = 1'b1;
					ddelay = response_delay();
					mem_rdata <= dmem[mem_addr[11:2]];
					mem_rdata_valid <= (ddelay == 0);
				end
			end
		end
	end

	// Reference model, one instruction per call
	function automatic void ref_step();
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v;
		logic [31:0] addr;
		logic [31:0] word;
		logic [31:0] imm_i;
		logic [31:0] next;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic        take;
		int          nbytes;
		inst = imem[ref_pc[7:2]];
		opc = inst[6:0];
		f3 = inst[14:12];
		a = ref_regs[inst[19:15]];
		b = ref_regs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		v = '0;
		next = ref_pc + 32'd4;
		exp_wen = 1'b1;
		exp_store = 1'b0;
		case (opc)
			7'h33, 7'h13: begin
				if (opc == 7'h13) b = imm_i;
				case (f3)
					3'd0: v = (opc == 7'h33 && inst[30]) ? a - b : a + b;
					3'd1: v = a << b[4:0];
					3'd2: v = {31'b0, $signed(a) < $signed(b)};
					3'd3: v = {31'b0, a < b};
					3'd4: v = a ^ b;
					3'd5: begin
						if (inst[30]) v = $signed(a) >>> b[4:0];
						else v = a >> b[4:0];
					end
					3'd6: v = a | b;
					default: v = a & b;
				endcase
			end
			7'h37: v = {inst[31:12], 12'b0};
			7'h17: v = ref_pc + {inst[31:12], 12'b0};
			7'h6f: begin
				v = ref_pc + 32'd4;
				next = ref_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			7'h67: begin
				v = ref_pc + 32'd4;
				next = (a + imm_i) & ~32'd1;
			end
			7'h63: begin
				exp_wen = 1'b0;
				case (f3)
					3'd0: take = a == b;
					3'd1: take = a != b;
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					default: take = a >= b;
				endcase
				if (take) next = ref_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			7'h03: begin
				addr = a + imm_i;
				word = ref_mem[addr[11:2]] >> {addr[1:0], 3'b000};
				case (f3)
					3'd0: v = {{24{word[7]}}, word[7:0]};
					3'd4: v = {24'b0, word[7:0]};
					3'd1: v = {{16{word[15]}}, word[15:0]};
					3'd5: v = {16'b0, word[15:0]};
					default: v = word;
				endcase
			end
			7'h23: begin
				exp_wen = 1'b0;
				exp_store = 1'b1;
				addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
				exp_saddr = {addr[31:2], 2'b00};
				// Access size in bytes
				nbytes = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
				// Lane k carries byte k mod size of the value
				// Strobe covers size bytes from the offset
				for (int k = 0; k < 4; k++) begin
					exp_swdata[8*k +: 8] = b[8*(k % nbytes) +: 8];
					exp_sstrb[k] = (k >= int'(addr[1:0])) && (k < int'(addr[1:0]) + nbytes);
				end
				for (int k = 0; k < 4; k++) begin
					if (exp_sstrb[k]) ref_mem[addr[11:2]][8*k +: 8] = exp_swdata[8*k +: 8];
				end
			end
			// Unknown opcode, no write
			default: exp_wen = 1'b0;
		endcase
		exp_pc = ref_pc;
		exp_rd = inst[11:7];
		exp_wdata = v;
		if (exp_wen && exp_rd != 5'd0) ref_regs[exp_rd] = v;
		ref_pc = next;
	endfunction

endmodule

`default_nettype wire
